/* design/hyperbus_pkg.sv */
`default_nettype none

package hyperbus_pkg;

	// chip select high time between operations, in clk_i cycles
	localparam int T_CSH = 4;
	// chip select fall to first bus clock edge
	localparam int T_PRE = 4;
	// last bus clock edge to chip select rise
	localparam int T_POST = 4;
	// bus clocks allowed for the read data phase
	localparam int READ_TIMEOUT = 20;
	// smallest access latency the device accepts
	localparam int MIN_TACC = 2;

	localparam int CA_BYTES = 6;
	localparam int MEM_BYTES = 4;
	// registers are 16 bits wide
	localparam int REG_BYTES = 2;

	typedef logic [31:0] word_t;
	typedef logic [47:0] ca_t;
	typedef logic [7:0] hb_byte_t;
	typedef logic [3:0] byte_sel_t;
	typedef logic [3:0] tacc_t;
	typedef logic [5:0] cnt_t;

	typedef enum logic [2:0] {
		IDLE,
		PRE,
		CA,
		LATENCY,
		WRITE,
		READ,
		POST
	} bus_phase_t;

endpackage

`default_nettype wire

/* design/hyperbus_sequencer.sv */
`default_nettype none

module hyperbus_sequencer (
	input  wire                            clk_i,
	input  wire                            rst_i,
	input  wire                            valid_i,
	input  wire                            wren_i,
	input  wire                            regspace_i,
	input  wire  hyperbus_pkg::word_t      addr_i,
	input  wire  hyperbus_pkg::byte_sel_t  sel_i,
	input  wire  hyperbus_pkg::word_t      data_i,
	input  wire  hyperbus_pkg::tacc_t      tacc_i,
	input  wire                            fixed_latency_i,
	input  wire                            double_latency_i,
	input  wire                            rwds_double_i,
	input  wire  [2:0]                     bytes_left_i,
	output hyperbus_pkg::bus_phase_t       phase_o,
	output hyperbus_pkg::cnt_t             byte_idx_o,
	output logic                           read_op_o,
	output logic                           reg_access_o,
	output hyperbus_pkg::ca_t              ca_word_o,
	output hyperbus_pkg::word_t            wr_data_o,
	output hyperbus_pkg::byte_sel_t        wr_sel_o,
	output logic                           ready_o,
	output logic                           read_timeout_o
);
	import hyperbus_pkg::*;

	bus_phase_t phase_q;
	cnt_t       cnt_q;
	cnt_t       latency;
	ca_t        ca_q;
	word_t      wr_data_q;
	byte_sel_t  wr_sel_q;
	tacc_t      tacc_q;
	logic       fixed_q;
	logic       double_q;
	logic       valid_q;
	logic       busy_q;
	logic       timeout_q;
	logic       valid_start;
	logic       read_op;
	logic       long_latency;

	// a request is a rising edge of valid_i
	assign valid_start = valid_i & ~valid_q;
	assign read_op = ca_q[47];

	// fixed mode takes the multiplier from config, variable mode from the device
	assign long_latency = fixed_q ? double_q : rwds_double_i;

	always_comb begin
		latency = long_latency ? cnt_t'({tacc_q, 2'b00}) : cnt_t'({tacc_q, 1'b0});
		// read data comes half a bus clock late, so a read waits one cycle more
		latency = latency - cnt_t'(read_op ? 2 : 3);
	end

	always_ff @(posedge clk_i) begin
		if (valid_start && !busy_q) begin
			wr_data_q <= data_i;
			wr_sel_q <= sel_i;
			// read/write, space, linear burst, row address, reserved, column
			ca_q <= {~wren_i, regspace_i, 1'b1, addr_i[31:3], 13'h0000, addr_i[2:0]};
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			phase_q <= IDLE;
			cnt_q <= cnt_t'(T_CSH);
			valid_q <= 1'b0;
			busy_q <= 1'b0;
			timeout_q <= 1'b0;
			tacc_q <= tacc_t'(MIN_TACC);
			fixed_q <= 1'b0;
			double_q <= 1'b0;
		end else begin
			valid_q <= valid_i;
			if (valid_start && !busy_q) begin
				busy_q <= 1'b1;
				timeout_q <= 1'b0;
				tacc_q <= (tacc_i < tacc_t'(MIN_TACC)) ? tacc_t'(MIN_TACC) : tacc_i;
				fixed_q <= fixed_latency_i;
				double_q <= double_latency_i;
			end
			if (cnt_q != '0) begin
				cnt_q <= cnt_q - 1'b1;
			end
			case (phase_q)
				IDLE: begin
					// a request may wait here until tCSH has run out
					if (cnt_q == '0 && (busy_q || valid_start)) begin
						phase_q <= PRE;
						cnt_q <= cnt_t'(T_PRE);
					end
				end
				PRE: begin
					if (cnt_q == '0) begin
						phase_q <= CA;
						cnt_q <= cnt_t'(CA_BYTES - 1);
					end
				end
				CA: begin
					if (cnt_q == '0) begin
						if (!read_op && ca_q[46]) begin
							// register writes have no latency
							phase_q <= WRITE;
							cnt_q <= cnt_t'(REG_BYTES - 1);
						end else begin
							phase_q <= LATENCY;
							cnt_q <= latency;
						end
					end
				end
				LATENCY: begin
					if (cnt_q == '0) begin
						if (read_op) begin
							phase_q <= READ;
							cnt_q <= cnt_t'(2 * READ_TIMEOUT - 2);
						end else begin
							phase_q <= WRITE;
							cnt_q <= cnt_t'(MEM_BYTES - 1);
						end
					end
				end
				WRITE: begin
					if (cnt_q == '0) begin
						phase_q <= POST;
						cnt_q <= cnt_t'(T_POST);
					end
				end
				READ: begin
					if (cnt_q == '0 || bytes_left_i == '0) begin
						phase_q <= POST;
						cnt_q <= cnt_t'(T_POST);
						timeout_q <= (cnt_q == '0) && (bytes_left_i != '0);
					end
				end
				POST: begin
					if (cnt_q == '0) begin
						phase_q <= IDLE;
						cnt_q <= cnt_t'(T_CSH);
						busy_q <= 1'b0;
					end
				end
				default: phase_q <= IDLE;
			endcase
		end
	end

	assign phase_o = phase_q;
	assign byte_idx_o = cnt_q;
	assign read_op_o = read_op;
	assign reg_access_o = ca_q[46];
	assign ca_word_o = ca_q;
	assign wr_data_o = wr_data_q;
	assign wr_sel_o = wr_sel_q;
	assign ready_o = ~busy_q;
	assign read_timeout_o = timeout_q;

	// FSM comes out of reset in IDLE
	assert property (@(posedge clk_i) rst_i |=> phase_q == IDLE);

	// a latency below the minimum would underflow the LATENCY count
	assert property (@(posedge clk_i) disable iff (rst_i) tacc_q >= tacc_t'(MIN_TACC));

endmodule

`default_nettype wire

/* design/hyperbus_bus_driver.sv */
`default_nettype none

module hyperbus_bus_driver (
	input  wire                            clk_i,
	input  wire                            rst_i,
	input  wire  hyperbus_pkg::bus_phase_t phase_i,
	input  wire  hyperbus_pkg::cnt_t       byte_idx_i,
	input  wire                            reg_access_i,
	input  wire  [2:0]                     bytes_left_i,
	input  wire  hyperbus_pkg::ca_t        ca_word_i,
	input  wire  hyperbus_pkg::word_t      wr_data_i,
	input  wire  hyperbus_pkg::byte_sel_t  wr_sel_i,
	output logic                           hb_csn_o,
	output logic                           hb_clk_o,
	output logic                           hb_clkn_o,
	output hyperbus_pkg::hb_byte_t         hb_dq_o,
	output logic                           hb_dq_oen_o,
	output logic                           hb_rwds_o,
	output logic                           hb_rwds_oen_o
);
	import hyperbus_pkg::*;

	logic     bus_clk_q;
	logic     clk_active;
	hb_byte_t dq;

	// the last read byte needs no further clock edge
	assign clk_active = (phase_i inside {CA, LATENCY, WRITE, READ}) &&
		!((phase_i == READ) && (bytes_left_i < 3'd2));

	// DDR bus clock, toggled half a cycle after DQ changes
	always_ff @(negedge clk_i) begin
		if (rst_i) begin
			bus_clk_q <= 1'b0;
		end else begin
			bus_clk_q <= clk_active ? ~bus_clk_q : 1'b0;
		end
	end

	assign hb_clk_o = bus_clk_q;
	assign hb_clkn_o = ~bus_clk_q;
	assign hb_csn_o = (phase_i == IDLE);

	// byte index counts down, so the most significant byte goes first
	always_comb begin
		dq = '0;
		case (phase_i)
			CA: begin
				if (byte_idx_i < cnt_t'(CA_BYTES)) begin
					dq = ca_word_i[8 * byte_idx_i +: 8];
				end
			end
			WRITE: begin
				if (byte_idx_i < cnt_t'(MEM_BYTES)) begin
					dq = wr_data_i[8 * byte_idx_i +: 8];
				end
			end
			default: dq = '0;
		endcase
	end

	assign hb_dq_o = dq;
	assign hb_dq_oen_o = !(phase_i inside {CA, WRITE});

	// RWDS high masks a byte, register writes leave RWDS to the device
	assign hb_rwds_oen_o = (phase_i != WRITE) || reg_access_i;
	assign hb_rwds_o = (phase_i == WRITE && !reg_access_i) ? ~wr_sel_i[byte_idx_i[1:0]] : 1'b0;

	// DQ is driven only in CA or WRITE, and only while the index points at a real byte
	assert property (@(posedge clk_i) disable iff (rst_i)
		!hb_dq_oen_o |->
			(phase_i == CA && byte_idx_i < cnt_t'(CA_BYTES)) ||
			(phase_i == WRITE &&
				byte_idx_i < cnt_t'(reg_access_i ? REG_BYTES : MEM_BYTES)));

endmodule

`default_nettype wire

/* design/hyperbus_read_capture.sv */
`default_nettype none

module hyperbus_read_capture (
	input  wire                            clk_i,
	input  wire                            rst_i,
	input  wire  hyperbus_pkg::bus_phase_t phase_i,
	input  wire  hyperbus_pkg::cnt_t       byte_idx_i,
	input  wire                            read_op_i,
	input  wire                            reg_access_i,
	input  wire                            hb_rwds_i,
	input  wire  hyperbus_pkg::hb_byte_t   hb_dq_i,
	output logic                           rwds_double_o,
	output logic [2:0]                     bytes_left_o,
	output hyperbus_pkg::word_t            data_o
);
	import hyperbus_pkg::*;

	logic       rwds_double_q;
	logic       rwds_prev_q;
	logic [2:0] bytes_left_q;
	word_t      data_q;
	logic       strobe;
	logic       take_byte;

	// even bytes arrive with RWDS high, odd bytes on the low half after it
	assign strobe = bytes_left_q[0] ? rwds_prev_q : hb_rwds_i;
	assign take_byte = (phase_i == READ) && strobe && (bytes_left_q != '0);

	always_ff @(negedge clk_i) begin
		if (rst_i) begin
			rwds_double_q <= 1'b1;
			rwds_prev_q <= 1'b0;
			bytes_left_q <= '0;
		end else begin
			// device default is double latency
			if (phase_i == IDLE) begin
				rwds_double_q <= 1'b1;
			end
			// device flags its latency on RWDS in the middle of CA
			if (phase_i == CA && byte_idx_i == cnt_t'(2)) begin
				rwds_double_q <= hb_rwds_i;
				if (!read_op_i) begin
					bytes_left_q <= '0;
				end else if (reg_access_i) begin
					bytes_left_q <= 3'(REG_BYTES);
				end else begin
					bytes_left_q <= 3'(MEM_BYTES);
				end
			end
			if (phase_i == READ) begin
				rwds_prev_q <= hb_rwds_i;
			end
			if (take_byte) begin
				bytes_left_q <= bytes_left_q - 1'b1;
			end
		end
	end

	// cleared in PRE so a register read leaves the upper half zero
	always_ff @(negedge clk_i) begin
		if (phase_i == PRE) begin
			data_q <= '0;
		end else if (take_byte) begin
			data_q[8 * (bytes_left_q - 1) +: 8] <= hb_dq_i;
		end
	end

	assign rwds_double_o = rwds_double_q;
	assign bytes_left_o = bytes_left_q;
	assign data_o = data_q;

	assert property (@(negedge clk_i) disable iff (rst_i) bytes_left_q <= 3'(MEM_BYTES));

endmodule

`default_nettype wire

/* design/hyperram_ctrl.sv */
`default_nettype none

module hyperram_ctrl (
	input  wire                            clk_i,
	input  wire                            rst_i,
	input  wire                            valid_i,
	input  wire                            wren_i,
	input  wire                            regspace_i,
	input  wire  hyperbus_pkg::word_t      addr_i,
	input  wire  hyperbus_pkg::byte_sel_t  sel_i,
	input  wire  hyperbus_pkg::word_t      data_i,
	input  wire  hyperbus_pkg::tacc_t      tacc_i,
	input  wire                            fixed_latency_i,
	input  wire                            double_latency_i,
	output wire                            ready_o,
	output wire  hyperbus_pkg::word_t      data_o,
	output wire                            read_timeout_o,
	output wire                            hb_rstn_o,
	output wire                            hb_csn_o,
	output wire                            hb_clk_o,
	output wire                            hb_clkn_o,
	output wire  hyperbus_pkg::hb_byte_t   hb_dq_o,
	output wire                            hb_dq_oen_o,
	output wire                            hb_rwds_o,
	output wire                            hb_rwds_oen_o,
	input  wire  hyperbus_pkg::hb_byte_t   hb_dq_i,
	input  wire                            hb_rwds_i
);
	import hyperbus_pkg::*;

	bus_phase_t phase;
	cnt_t       byte_idx;
	logic       read_op;
	logic       reg_access;
	ca_t        ca_word;
	word_t      wr_data;
	byte_sel_t  wr_sel;
	logic       rwds_double;
	logic [2:0] bytes_left;

	// device reset follows the controller reset
	assign hb_rstn_o = ~rst_i;

	hyperbus_sequencer sequencer_i (
		.clk_i            (clk_i),
		.rst_i            (rst_i),
		.valid_i          (valid_i),
		.wren_i           (wren_i),
		.regspace_i       (regspace_i),
		.addr_i           (addr_i),
		.sel_i            (sel_i),
		.data_i           (data_i),
		.tacc_i           (tacc_i),
		.fixed_latency_i  (fixed_latency_i),
		.double_latency_i (double_latency_i),
		.rwds_double_i    (rwds_double),
		.bytes_left_i     (bytes_left),
		.phase_o          (phase),
		.byte_idx_o       (byte_idx),
		.read_op_o        (read_op),
		.reg_access_o     (reg_access),
		.ca_word_o        (ca_word),
		.wr_data_o        (wr_data),
		.wr_sel_o         (wr_sel),
		.ready_o          (ready_o),
		.read_timeout_o   (read_timeout_o)
	);

	hyperbus_bus_driver bus_driver_i (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.phase_i       (phase),
		.byte_idx_i    (byte_idx),
		.reg_access_i  (reg_access),
		.bytes_left_i  (bytes_left),
		.ca_word_i     (ca_word),
		.wr_data_i     (wr_data),
		.wr_sel_i      (wr_sel),
		.hb_csn_o      (hb_csn_o),
		.hb_clk_o      (hb_clk_o),
		.hb_clkn_o     (hb_clkn_o),
		.hb_dq_o       (hb_dq_o),
		.hb_dq_oen_o   (hb_dq_oen_o),
		.hb_rwds_o     (hb_rwds_o),
		.hb_rwds_oen_o (hb_rwds_oen_o)
	);

	hyperbus_read_capture read_capture_i (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.phase_i       (phase),
		.byte_idx_i    (byte_idx),
		.read_op_i     (read_op),
		.reg_access_i  (reg_access),
		.hb_rwds_i     (hb_rwds_i),
		.hb_dq_i       (hb_dq_i),
		.rwds_double_o (rwds_double),
		.bytes_left_o  (bytes_left),
		.data_o        (data_o)
	);

endmodule

`default_nettype wire

/* testbench/hyperram_dev_model.sv */
`default_nettype none

module hyperram_dev_model (
	input  wire        hb_rstn_i,
	input  wire        hb_csn_i,
	input  wire        hb_clk_i,
	input  wire [7:0]  hb_dq_i,
	input  wire        hb_dq_oen_i,
	input  wire        hb_rwds_i,
	input  wire        hb_rwds_oen_i,
	input  wire        lat_double_i,
	input  wire [4:0]  lat_clocks_i,
	input  wire        withhold_i,
	output logic [7:0] hb_dq_o,
	output logic       hb_rwds_o
);
	logic [31:0] mem [0:63];
	logic [15:0] cfg_reg;
	logic [47:0] ca;
	logic [31:0] rd_word;
	logic [7:0]  dq_in;
	logic [5:0]  widx;
	logic        is_read;
	logic        is_reg;
	logic        clk_prev;
	int          edge_cnt;
	int          data_start;
	int          n_bytes;
	int          k;

	initial begin
		for (int i = 0; i < 64; i++) begin
			mem[i] = 32'h9e3779b9 * (i + 1);
		end
		cfg_reg = 16'h8f1f;
		ca = '0;
		edge_cnt = 0;
		clk_prev = 1'b0;
		hb_dq_o = 8'h00;
		hb_rwds_o = 1'b0;
	end

	// undriven DQ shows up as X in the decoded command or data
	assign dq_in = hb_dq_oen_i ? 8'hxx : hb_dq_i;

	always @(hb_csn_i or hb_clk_i or hb_rstn_i) begin
		if (!hb_rstn_i || hb_csn_i) begin
			edge_cnt = 0;
			hb_dq_o = 8'h00;
			hb_rwds_o = 1'b0;
			clk_prev = hb_clk_i;
		end else if (hb_clk_i === clk_prev) begin
			// chip select just fell, so signal the latency on RWDS
			hb_rwds_o = lat_double_i;
		end else begin
			clk_prev = hb_clk_i;
			if (edge_cnt < 6) begin
				ca = {ca[39:0], dq_in};
				if (edge_cnt == 5) begin
					is_read = ca[47];
					is_reg = ca[46];
					widx = {ca[18:16], ca[2:0]};
					n_bytes = is_reg ? 2 : 4;
					// latency counted from the rising edge of the third CA clock
					data_start = (is_reg && !is_read) ? 6 : 4 + 2 * lat_clocks_i;
					rd_word = is_reg ? {cfg_reg, 16'h0000} : mem[widx];
					hb_rwds_o = 1'b0;
				end
			end else if (edge_cnt >= data_start && edge_cnt < data_start + n_bytes) begin
				k = edge_cnt - data_start;
				if (is_read) begin
					if (!withhold_i) begin
						hb_dq_o = rd_word[8 * (3 - k) +: 8];
						hb_rwds_o = (k % 2 == 0);
					end
				end else if (is_reg) begin
					cfg_reg[8 * (1 - k) +: 8] = dq_in;
				end else if (!hb_rwds_oen_i && !hb_rwds_i) begin
					mem[widx][8 * (3 - k) +: 8] = dq_in;
				end
			end
			edge_cnt = edge_cnt + 1;
		end
	end

endmodule

`default_nettype wire

/* testbench/hyperram_ctrl_tb.sv */
`default_nettype none

module hyperram_ctrl_tb;
	localparam int N_OPS = 200;
	localparam int ADDR_WORDS = 16;
	localparam int MEM_WORDS = 64;
	localparam int CYCLE_LIMIT = N_OPS * 200;

	logic        clk_i;
	logic        rst_i;
	logic        valid_i;
	logic        wren_i;
	logic        regspace_i;
	logic [31:0] addr_i;
	logic [3:0]  sel_i;
	logic [31:0] data_i;
	logic [3:0]  tacc_i;
	logic        fixed_latency_i;
	logic        double_latency_i;
	wire         ready_o;
	wire  [31:0] data_o;
	wire         read_timeout_o;
	wire         hb_rstn;
	wire         hb_csn;
	wire         hb_clk;
	wire         hb_clkn;
	wire  [7:0]  hb_dq_ctrl;
	wire         hb_dq_oen;
	wire         hb_rwds_ctrl;
	wire         hb_rwds_oen;
	wire  [7:0]  hb_dq_dev;
	wire         hb_rwds_dev;
	logic        dev_double;
	logic [4:0]  dev_lat_clocks;
	logic        dev_withhold;

	logic [31:0] ref_mem [0:MEM_WORDS-1];
	logic [15:0] ref_reg;
	logic        op_wr;
	logic        op_reg;
	logic        op_withhold;
	logic        op_spurious;
	logic        op_flag;
	logic [5:0]  op_addr;
	logic [31:0] op_data;
	logic [3:0]  op_sel;
	logic [3:0]  op_tacc;
	logic        op_fixed;
	logic        op_double;
	int          op_num = 0;
	int          errors = 0;
	int          cycles = 0;

	hyperram_ctrl hyperram_ctrl_i (
		.clk_i            (clk_i),
		.rst_i            (rst_i),
		.valid_i          (valid_i),
		.wren_i           (wren_i),
		.regspace_i       (regspace_i),
		.addr_i           (addr_i),
		.sel_i            (sel_i),
		.data_i           (data_i),
		.tacc_i           (tacc_i),
		.fixed_latency_i  (fixed_latency_i),
		.double_latency_i (double_latency_i),
		.ready_o          (ready_o),
		.data_o           (data_o),
		.read_timeout_o   (read_timeout_o),
		.hb_rstn_o        (hb_rstn),
		.hb_csn_o         (hb_csn),
		.hb_clk_o         (hb_clk),
		.hb_clkn_o        (hb_clkn),
		.hb_dq_o          (hb_dq_ctrl),
		.hb_dq_oen_o      (hb_dq_oen),
		.hb_rwds_o        (hb_rwds_ctrl),
		.hb_rwds_oen_o    (hb_rwds_oen),
		.hb_dq_i          (hb_dq_dev),
		.hb_rwds_i        (hb_rwds_dev)
	);

	hyperram_dev_model dev_i (
		.hb_rstn_i     (hb_rstn),
		.hb_csn_i      (hb_csn),
		.hb_clk_i      (hb_clk),
		.hb_dq_i       (hb_dq_ctrl),
		.hb_dq_oen_i   (hb_dq_oen),
		.hb_rwds_i     (hb_rwds_ctrl),
		.hb_rwds_oen_i (hb_rwds_oen),
		.lat_double_i  (dev_double),
		.lat_clocks_i  (dev_lat_clocks),
		.withhold_i    (dev_withhold),
		.hb_dq_o       (hb_dq_dev),
		.hb_rwds_o     (hb_rwds_dev)
	);

	initial begin
		clk_i = 1'b0;
		forever begin
			#4;
			clk_i = ~clk_i;
		end
	end

	always @(posedge clk_i) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: operations still running after %0d cycles", CYCLE_LIMIT);
			$display("%0d operations started, %0d errors", op_num, errors);
			$display("Test FAILED");
			$finish;
		end
	end

	task automatic report_mismatch(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		errors++;
		$display("Error: %s = %h, expected %h (operation %0d)", name, actual, expected, op_num);
	endtask

	// the inverted bus clock mirrors the bus clock
	always @(posedge clk_i) begin
		if (!rst_i && hb_clkn !== ~hb_clk) begin
			report_mismatch("hb_clkn_o", {31'h0, hb_clkn}, {31'h0, ~hb_clk});
		end
	end

	function automatic logic [31:0] expand_mask(input logic [3:0] sel);
		return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
	endfunction

	// one host operation, with an optional ignored request while busy
	task automatic run_operation();
		logic [31:0] expected;
		int          tacc_eff;
		int          mult;
		tacc_eff = (op_tacc < 2) ? 2 : int'(op_tacc);
		if (op_fixed) begin
			mult = op_double ? 2 : 1;
		end else begin
			mult = op_flag ? 2 : 1;
		end
		@(posedge clk_i);
		#1;
		dev_double = op_flag;
		dev_lat_clocks = 5'(tacc_eff * mult);
		dev_withhold = op_withhold;
		wren_i = op_wr;
		regspace_i = op_reg;
		addr_i = {26'h0, op_addr};
		data_i = op_data;
		sel_i = op_sel;
		tacc_i = op_tacc;
		fixed_latency_i = op_fixed;
		double_latency_i = op_double;
		valid_i = 1'b1;
		@(posedge clk_i);
		#1;
		valid_i = 1'b0;
		if (ready_o !== 1'b0) begin
			report_mismatch("ready_o", 32'(ready_o), 32'h0);
		end
		if (op_spurious) begin
			@(posedge clk_i);
			#1;
			wren_i = 1'b1;
			regspace_i = ~op_reg;
			data_i = ~op_data;
			sel_i = 4'hf;
			valid_i = 1'b1;
			@(posedge clk_i);
			#1;
			valid_i = 1'b0;
		end
		while (ready_o !== 1'b1) begin
			@(posedge clk_i);
			#1;
		end
		if (op_wr && op_reg) begin
			ref_reg = op_data[15:0];
		end else if (op_wr) begin
			ref_mem[op_addr] = (ref_mem[op_addr] & ~expand_mask(op_sel)) |
				(op_data & expand_mask(op_sel));
		end else if (!op_withhold) begin
			expected = op_reg ? {16'h0000, ref_reg} : ref_mem[op_addr];
			if (data_o !== expected) begin
				report_mismatch("data_o", data_o, expected);
			end
		end
		if (read_timeout_o !== (!op_wr && op_withhold)) begin
			report_mismatch("read_timeout_o", 32'(read_timeout_o), 32'(!op_wr && op_withhold));
		end
		if (hb_csn !== 1'b1) begin
			report_mismatch("hb_csn_o", 32'(hb_csn), 32'h1);
		end
	endtask

	initial begin
		void'($urandom(5));
		rst_i = 1'b1;
		valid_i = 1'b0;
		wren_i = 1'b0;
		regspace_i = 1'b0;
		addr_i = '0;
		sel_i = '0;
		data_i = '0;
		tacc_i = '0;
		fixed_latency_i = 1'b0;
		double_latency_i = 1'b0;
		dev_double = 1'b0;
		dev_lat_clocks = 5'd2;
		dev_withhold = 1'b0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			ref_mem[i] = 32'h9e3779b9 * (i + 1);
		end
		ref_reg = 16'h8f1f;
		repeat (8) @(posedge clk_i);
		#1;
		if (hb_rstn !== 1'b0) begin
			report_mismatch("hb_rstn_o", 32'(hb_rstn), 32'h0);
		end
		rst_i = 1'b0;
		if (ready_o !== 1'b1) begin
			report_mismatch("ready_o", 32'(ready_o), 32'h1);
		end
		if (hb_csn !== 1'b1) begin
			report_mismatch("hb_csn_o", 32'(hb_csn), 32'h1);
		end
		if (read_timeout_o !== 1'b0) begin
			report_mismatch("read_timeout_o", 32'(read_timeout_o), 32'h0);
		end
		if (hb_clk !== 1'b0) begin
			report_mismatch("hb_clk_o", 32'(hb_clk), 32'h0);
		end
		if ({hb_dq_oen, hb_rwds_oen} !== 2'b11) begin
			report_mismatch("hb_dq_oen_o/hb_rwds_oen_o", 32'({hb_dq_oen, hb_rwds_oen}), 32'h3);
		end
		for (int n = 0; n < N_OPS; n++) begin
			op_num = n;
			op_wr = ($urandom % 2 == 0);
			op_reg = ($urandom % 4 == 0);
			op_withhold = !op_wr && ($urandom % 8 == 0);
			op_spurious = ($urandom % 4 == 0);
			op_addr = 6'($urandom % ADDR_WORDS);
			op_data = $urandom;
			op_sel = 4'($urandom);
			op_tacc = 4'($urandom % 7);
			op_fixed = ($urandom % 2 == 0);
			op_double = ($urandom % 2 == 0);
			op_flag = ($urandom % 2 == 0);
			run_operation();
		end
		// ignored requests must have left the device memory alone
		for (int i = 0; i < MEM_WORDS; i++) begin
			if (dev_i.mem[i] !== ref_mem[i]) begin
				report_mismatch($sformatf("mem[%0d]", i), dev_i.mem[i], ref_mem[i]);
			end
		end
		if (dev_i.cfg_reg !== ref_reg) begin
			report_mismatch("cfg_reg", 32'(dev_i.cfg_reg), 32'(ref_reg));
		end
		$display("%0d operations, %0d errors", N_OPS, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
design/hyperbus_pkg.sv
design/hyperbus_sequencer.sv
design/hyperbus_bus_driver.sv
design/hyperbus_read_capture.sv
design/hyperram_ctrl.sv
testbench/hyperram_dev_model.sv
testbench/hyperram_ctrl_tb.sv

/* Bender.yml */
package:
  name: hyperram_ctrl

sources:
  - design/hyperbus_pkg.sv
  - design/hyperbus_sequencer.sv
  - design/hyperbus_bus_driver.sv
  - design/hyperbus_read_capture.sv
  - design/hyperram_ctrl.sv
  - target: test
    files:
      - testbench/hyperram_dev_model.sv
      - testbench/hyperram_ctrl_tb.sv
